// File: include/sme_params.svh
`ifndef SME_PARAMS_SVH
`define SME_PARAMS_SVH

// character width in bits
`define SME_CHAR_W 8

// capacities in characters
`define SME_STR_MAX 32
`define SME_PAT_MAX 8

// pattern metacharacters
`define SME_HAT 8'h5e
`define SME_DOLLAR 8'h24
`define SME_DOT 8'h2e

// word separator, plain space
`define SME_SEP 8'h20

`endif

// File: logic/sme_text_pkg.sv
`include "sme_params.svh"

package sme_text_pkg;

    typedef logic [`SME_CHAR_W-1:0] char_t;

    // character 0 sits in the low byte
    typedef logic [`SME_CHAR_W*`SME_STR_MAX-1:0] text_t;
    typedef logic [`SME_CHAR_W*`SME_PAT_MAX-1:0] body_t;

    // lengths reach the full capacity, positions stop one short
    typedef logic [$clog2(`SME_STR_MAX+1)-1:0] str_len_t;
    typedef logic [$clog2(`SME_STR_MAX)-1:0] str_pos_t;
    typedef logic [$clog2(`SME_PAT_MAX+1)-1:0] pat_len_t;

endpackage

// File: logic/sme_ctrl_pkg.sv
package sme_ctrl_pkg;

    // job controller
    typedef enum logic [2:0] {
        IDLE,
        RD_STRING,
        RD_PATTERN,
        COMPARE,
        DONE
    } sme_state_t;

    // scanner
    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_RUN,
        SCAN_END
    } scan_state_t;

endpackage

// File: logic/sme_ctrl.sv
`timescale 1ns/1ps

module sme_ctrl
    import sme_ctrl_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic isstring,
    input  logic ispattern,
    input  logic scan_done,
    output logic text_wr,
    output logic text_first,
    output logic pat_wr,
    output logic pat_first,
    output logic scan_start,
    output logic valid
);

    sme_state_t state;
    sme_state_t next_state;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE, RD_STRING:
            begin
                if (isstring)
                    next_state = RD_STRING;
                else if (ispattern)
                    next_state = RD_PATTERN;
                else
                    next_state = IDLE;
            end
            RD_PATTERN:
            begin
                if (!ispattern)
                    next_state = COMPARE;
            end
            COMPARE:
            begin
                if (scan_done)
                    next_state = DONE;
            end
            DONE:
                next_state = IDLE;
            default:
                next_state = IDLE;
        endcase
    end

    // writes land on the edge that samples the input strobe
    assign text_wr    = isstring;
    assign text_first = isstring && (state != RD_STRING);
    assign pat_wr     = ispattern;
    assign pat_first  = ispattern && (state != RD_PATTERN);

    // pattern run just ended
    assign scan_start = (state == RD_PATTERN) && !ispattern;
    assign valid      = (state == DONE);

    a_strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(isstring && ispattern))
        else $error("isstring and ispattern high together");

    a_quiet_while_busy: assert property (@(posedge clk) disable iff (reset)
        (state == COMPARE || state == DONE) |-> !(isstring || ispattern))
        else $error("input strobe during search");

endmodule

// File: logic/text_buffer.sv
`timescale 1ns/1ps
`include "sme_params.svh"

module text_buffer
    import sme_text_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  char_t    chardata,
    input  logic     text_wr,
    input  logic     text_first,
    output text_t    text,
    output str_len_t text_len
);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            text_len <= '0;
        end
        else if (text_wr)
        begin
            if (text_first)
                text_len <= str_len_t'(1);
            else if (text_len < str_len_t'(`SME_STR_MAX))
                text_len <= text_len + 1'b1;
        end
    end

    // character storage
    always_ff @(posedge clk)
    begin
        if (text_wr)
        begin
            if (text_first)
            begin
                text <= '0;
                text[`SME_CHAR_W-1:0] <= chardata;
            end
            else if (text_len < str_len_t'(`SME_STR_MAX))
            begin
                text[int'(text_len)*`SME_CHAR_W +: `SME_CHAR_W] <= chardata;
            end
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        (text_wr && !text_first) |-> (text_len < str_len_t'(`SME_STR_MAX)))
        else $error("string longer than capacity");

endmodule

// File: logic/pattern_buffer.sv
`timescale 1ns/1ps
`include "sme_params.svh"

module pattern_buffer
    import sme_text_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  char_t    chardata,
    input  logic     pat_wr,
    input  logic     pat_first,
    output body_t    body,
    output pat_len_t body_len,
    output logic     anchor_start,
    output logic     anchor_end
);

    logic is_hat;
    logic is_dollar;
    logic append;

    assign is_hat    = (chardata == `SME_HAT);
    assign is_dollar = (chardata == `SME_DOLLAR);

    // hat only counts as an anchor in front, dollar is never stored
    assign append = pat_wr && !is_dollar && !(pat_first && is_hat);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            body_len     <= '0;
            anchor_start <= 1'b0;
            anchor_end   <= 1'b0;
        end
        else if (pat_wr)
        begin
            if (pat_first)
            begin
                anchor_start <= is_hat;
                body_len     <= (is_hat || is_dollar) ? pat_len_t'(0) : pat_len_t'(1);
            end
            else if (append && body_len < pat_len_t'(`SME_PAT_MAX))
            begin
                body_len <= body_len + 1'b1;
            end
            // a character after the dollar drops the end anchor
            anchor_end <= is_dollar;
        end
    end

    always_ff @(posedge clk)
    begin
        if (append)
        begin
            if (pat_first)
                body[`SME_CHAR_W-1:0] <= chardata;
            else if (body_len < pat_len_t'(`SME_PAT_MAX))
                body[int'(body_len)*`SME_CHAR_W +: `SME_CHAR_W] <= chardata;
        end
    end

    a_body_fits: assert property (@(posedge clk) disable iff (reset)
        (append && !pat_first) |-> (body_len < pat_len_t'(`SME_PAT_MAX)))
        else $error("pattern body longer than capacity");

endmodule

// File: logic/match_engine.sv
`timescale 1ns/1ps
`include "sme_params.svh"

module match_engine
    import sme_text_pkg::*;
    import sme_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     scan_start,
    input  text_t    text,
    input  str_len_t text_len,
    input  body_t    body,
    input  pat_len_t body_len,
    input  logic     anchor_start,
    input  logic     anchor_end,
    output logic     scan_done,
    output logic     match,
    output str_pos_t match_index
);

    scan_state_t state;
    str_len_t    pos;
    str_len_t    last_pos;
    logic        too_long;
    logic        body_ok;
    logic        start_ok;
    logic        end_ok;
    logic        hit;
    logic        started;

    // out of range reads as a plain zero byte
    function automatic char_t text_char(input text_t t, input int idx);
        char_t c;
        c = '0;
        if (idx >= 0 && idx < `SME_STR_MAX)
            c = t[idx*`SME_CHAR_W +: `SME_CHAR_W];
        return c;
    endfunction

    assign too_long = int'(body_len) > int'(text_len);
    assign last_pos = text_len - str_len_t'(body_len);

    always_comb
    begin
        char_t pc;
        body_ok = 1'b1;
        for (int i = 0; i < `SME_PAT_MAX; i++)
        begin
            pc = body[i*`SME_CHAR_W +: `SME_CHAR_W];
            if (i < int'(body_len) && pc != `SME_DOT && pc != text_char(text, int'(pos) + i))
                body_ok = 1'b0;
        end
    end

    // word boundaries on either side of the candidate
    assign start_ok = !anchor_start || pos == '0
                      || text_char(text, int'(pos) - 1) == `SME_SEP;
    assign end_ok   = !anchor_end || int'(pos) + int'(body_len) == int'(text_len)
                      || text_char(text, int'(pos) + int'(body_len)) == `SME_SEP;
    assign hit      = body_ok && start_ok && end_ok;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state       <= SCAN_IDLE;
            pos         <= '0;
            match       <= 1'b0;
            match_index <= '0;
        end
        else
        begin
            case (state)
                SCAN_IDLE:
                begin
                    if (scan_start)
                    begin
                        state       <= SCAN_RUN;
                        pos         <= '0;
                        match       <= 1'b0;
                        match_index <= '0;
                    end
                end
                SCAN_RUN:
                begin
                    if (too_long)
                    begin
                        state <= SCAN_END;
                    end
                    else if (hit)
                    begin
                        match       <= 1'b1;
                        match_index <= str_pos_t'(pos);
                        state       <= SCAN_END;
                    end
                    else if (pos == last_pos)
                        state <= SCAN_END;
                    else
                        pos <= pos + 1'b1;
                end
                default:
                    state <= SCAN_IDLE;
            endcase
        end
    end

    assign scan_done = (state == SCAN_END);

    // armed by scan_start, spent by scan_done
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            started <= 1'b0;
        else if (scan_start)
            started <= 1'b1;
        else if (scan_done)
            started <= 1'b0;
    end

    a_done_after_start: assert property (@(posedge clk) disable iff (reset)
        scan_done |-> started)
        else $error("scan_done without scan_start");

endmodule

// File: logic/sme_top.sv
`timescale 1ns/1ps

module sme_top
    import sme_text_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  char_t    chardata,
    input  logic     isstring,
    input  logic     ispattern,
    output logic     valid,
    output logic     match,
    output str_pos_t match_index
);

    logic     text_wr;
    logic     text_first;
    logic     pat_wr;
    logic     pat_first;
    logic     scan_start;
    logic     scan_done;
    text_t    text;
    str_len_t text_len;
    body_t    body;
    pat_len_t body_len;
    logic     anchor_start;
    logic     anchor_end;

    sme_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .isstring   (isstring),
        .ispattern  (ispattern),
        .scan_done  (scan_done),
        .text_wr    (text_wr),
        .text_first (text_first),
        .pat_wr     (pat_wr),
        .pat_first  (pat_first),
        .scan_start (scan_start),
        .valid      (valid)
    );

    text_buffer u_text (
        .clk        (clk),
        .reset      (reset),
        .chardata   (chardata),
        .text_wr    (text_wr),
        .text_first (text_first),
        .text       (text),
        .text_len   (text_len)
    );

    pattern_buffer u_pattern (
        .clk          (clk),
        .reset        (reset),
        .chardata     (chardata),
        .pat_wr       (pat_wr),
        .pat_first    (pat_first),
        .body         (body),
        .body_len     (body_len),
        .anchor_start (anchor_start),
        .anchor_end   (anchor_end)
    );

    match_engine u_engine (
        .clk          (clk),
        .reset        (reset),
        .scan_start   (scan_start),
        .text         (text),
        .text_len     (text_len),
        .body         (body),
        .body_len     (body_len),
        .anchor_start (anchor_start),
        .anchor_end   (anchor_end),
        .scan_done    (scan_done),
        .match        (match),
        .match_index  (match_index)
    );

endmodule

// File: test/sme_tb.sv
`timescale 1ns/1ps
`include "sme_params.svh"

module sme_tb
    import sme_text_pkg::*;
;

    logic     clk;
    logic     reset;
    char_t    chardata;
    logic     isstring;
    logic     ispattern;
    logic     valid;
    logic     match;
    str_pos_t match_index;

    int          value_errors = 0;
    int          timeout_errors = 0;
    int          checks = 0;
    logic [31:0] lfsr_state = 32'h98df;

    // copy of the last random string for the reference model
    char_t tb_text [`SME_STR_MAX];
    int    tb_len = 0;

    sme_top DUT (
        .clk         (clk),
        .reset       (reset),
        .chardata    (chardata),
        .isstring    (isstring),
        .ispattern   (ispattern),
        .valid       (valid),
        .match       (match),
        .match_index (match_index)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois lfsr stepped once per bit
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            v = (v << 1) | int'(lfsr_state[0]);
            if (lfsr_state[0])
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            else
                lfsr_state = lfsr_state >> 1;
        end
        return v;
    endfunction

    // letters a to d plus the separator
    function automatic char_t pick_char();
        int k;
        k = rand_bits(3) % 5;
        if (k == 4)
            return `SME_SEP;
        return char_t'(8'h61 + k);
    endfunction

    // reference search over tb_text with the anchors stripped
    function automatic bit find_match(input string pat, output int at);
        bit hat;
        bit dol;
        int b0;
        int blen;
        bit ok;
        hat = pat.len() > 0 && pat[0] == `SME_HAT;
        dol = pat.len() > 0 && pat[pat.len()-1] == `SME_DOLLAR;
        b0 = hat ? 1 : 0;
        blen = pat.len() - b0 - (dol ? 1 : 0);
        at = 0;
        for (int p = 0; p + blen <= tb_len; p++)
        begin
            ok = 1'b1;
            for (int i = 0; i < blen; i++)
                if (pat[b0+i] != `SME_DOT && pat[b0+i] != tb_text[p+i])
                    ok = 1'b0;
            if (hat && p > 0 && tb_text[p-1] != `SME_SEP)
                ok = 1'b0;
            if (dol && p + blen < tb_len && tb_text[p+blen] != `SME_SEP)
                ok = 1'b0;
            if (ok)
            begin
                at = p;
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp)
        begin
            value_errors++;
            $display("FAIL %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_pos(input str_pos_t got, input str_pos_t exp, input string what);
        checks++;
        if (got !== exp)
        begin
            value_errors++;
            $display("FAIL %0t ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // empty s keeps the stored string
    task automatic send_job(input string s, input string p, input logic exp_match,
                            input int exp_at, input string name);
        int  cycles;
        bit  seen;
        for (int i = 0; i < s.len(); i++)
        begin
            @(negedge clk);
            check_bit(valid, 1'b0, {name, " valid while loading"});
            isstring = 1'b1;
            chardata = s[i];
        end
        for (int i = 0; i < p.len(); i++)
        begin
            @(negedge clk);
            check_bit(valid, 1'b0, {name, " valid while loading"});
            isstring  = 1'b0;
            ispattern = 1'b1;
            chardata  = p[i];
        end
        @(negedge clk);
        check_bit(valid, 1'b0, {name, " valid at end of pattern"});
        isstring  = 1'b0;
        ispattern = 1'b0;
        chardata  = '0;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < 40)
        begin
            @(negedge clk);
            cycles++;
            seen = valid;
        end
        if (!seen)
        begin
            timeout_errors++;
            $display("timeout: no valid pulse within 40 cycles for job %s", name);
        end
        else
        begin
            check_bit(match, exp_match, {name, " match"});
            check_pos(match_index, str_pos_t'(exp_at), {name, " match_index"});
            @(negedge clk);
            check_bit(valid, 1'b0, {name, " valid after pulse"});
        end
    endtask

    task automatic idle_after_reset();
        for (int i = 0; i < 4; i++)
        begin
            @(negedge clk);
            check_bit(valid, 1'b0, "idle valid");
        end
        check_bit(match, 1'b0, "idle match");
        check_pos(match_index, '0, "idle match_index");
    endtask

    task automatic literal_patterns();
        send_job("abcabc", "bc", 1'b1, 1, "literal bc");
        send_job("abcabc", "abc", 1'b1, 0, "literal abc");
        send_job("xyab ab ab", "ab", 1'b1, 2, "earliest ab");
    endtask

    task automatic dot_and_absent();
        send_job("cat cot cut", "c.t", 1'b1, 0, "dot c.t");
        send_job("cat cot cut", ".ot", 1'b1, 4, "dot .ot");
        send_job("cat cot cut", "dog", 1'b0, 0, "absent dog");
        send_job("ab", "abc", 1'b0, 0, "body too long");
    endtask

    task automatic hat_anchor();
        send_job("seaside sea", "^sea", 1'b1, 0, "hat at start");
        send_job("one two", "^two", 1'b1, 4, "hat after space");
        send_job("beside aside", "^side", 1'b0, 0, "hat inside word");
    endtask

    task automatic dollar_anchor();
        send_job("abab ab", "ab$", 1'b1, 2, "dollar before space");
        send_job("xab", "ab$", 1'b1, 1, "dollar at end");
        send_job("abab ab", "^ab$", 1'b1, 5, "whole word");
        send_job("abc abd", "^ab$", 1'b0, 0, "no whole word");
    endtask

    task automatic kept_string();
        send_job("red green blue", "green", 1'b1, 4, "new string");
        send_job("", "blue", 1'b1, 10, "kept string");
        send_job("", "^r.d", 1'b1, 0, "kept string again");
    endtask

    task automatic random_jobs(input int n);
        string s;
        string p;
        int    slen;
        int    blen;
        int    at;
        bit    hit;
        for (int j = 0; j < n; j++)
        begin
            s = "";
            p = "";
            slen = 1 + rand_bits(5);
            for (int i = 0; i < slen; i++)
            begin
                tb_text[i] = pick_char();
                s = $sformatf("%s%c", s, tb_text[i]);
            end
            tb_len = slen;
            if (rand_bits(1))
                p = "^";
            blen = 1 + rand_bits(2);
            for (int i = 0; i < blen; i++)
            begin
                if (rand_bits(2) == 0)
                    p = $sformatf("%s%c", p, `SME_DOT);
                else
                    p = $sformatf("%s%c", p, pick_char());
            end
            if (rand_bits(1))
                p = {p, "$"};
            hit = find_match(p, at);
            send_job(s, p, hit, at, $sformatf("random %0d '%s' in '%s'", j, p, s));
        end
    endtask

    initial
    begin
        reset     = 1'b1;
        chardata  = '0;
        isstring  = 1'b0;
        ispattern = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        idle_after_reset();
        literal_patterns();
        dot_and_absent();
        hat_anchor();
        dollar_anchor();
        kept_string();
        random_jobs(50);

        $display("checks: %0d, value errors: %0d, timeouts: %0d",
                 checks, value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: sme.f
+incdir+include
logic/sme_text_pkg.sv
logic/sme_ctrl_pkg.sv
logic/sme_ctrl.sv
logic/text_buffer.sv
logic/pattern_buffer.sv
logic/match_engine.sv
logic/sme_top.sv
test/sme_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= sme_tb
FILELIST  ?= sme.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf $(BUILD_DIR)
